// File: common/stream_pkg.sv
package stream_pkg;

	////////////////////////////////////////////////////////////
	// Byte and word stream data
	////////////////////////////////////////////////////////////

	// One data byte on the input or output stream
	typedef logic [7:0] byte_t;

	// One FIFO word, four bytes little-endian
	// Byte 0 (first to arrive) sits in bits 7:0
	typedef logic [31:0] word_t;

	////////////////////////////////////////////////////////////
	// Drain FSM
	////////////////////////////////////////////////////////////

	// Idle waits for data and no hold, then issues the read
	// Fetch is the cycle where the RAM output becomes valid
	// Send shifts the four bytes out under the hold level
	typedef enum logic [1:0] {
		DR_IDLE  = 2'd0,
		DR_FETCH = 2'd1,
		DR_SEND  = 2'd2
	} drain_state_t;

endpackage

// File: common/fifo_pkg.sv
package fifo_pkg;

	////////////////////////////////////////////////////////////
	// Write side of the FIFO
	////////////////////////////////////////////////////////////

	// Single-cycle write strobe with its word
	typedef struct packed {
		logic              wr;
		stream_pkg::word_t data;
	} fifo_wr_t;

	////////////////////////////////////////////////////////////
	// FIFO status
	////////////////////////////////////////////////////////////

	// Ready drops in any cycle where a read owns the RAM port
	typedef struct packed {
		logic full;
		logic empty;
		logic ready;
	} fifo_status_t;

	////////////////////////////////////////////////////////////
	// RAM port operation
	////////////////////////////////////////////////////////////

	// One operation per cycle, chosen by the controller
	typedef enum logic [1:0] {
		MEM_IDLE  = 2'd0,
		MEM_WRITE = 2'd1,
		MEM_READ  = 2'd2
	} mem_op_t;

endpackage

// File: sfifo/sfifo_mem.sv
`timescale 1ns/1ns

module sfifo_mem #(
	parameter int LGFLEN = 3
) (
	input  logic              i_clk,
	// Operation for this cycle
	input  fifo_pkg::mem_op_t i_op,
	input  logic [LGFLEN-1:0] i_wr_addr,
	input  logic [LGFLEN-1:0] i_rd_addr,
	input  stream_pkg::word_t i_data,
	// Registered read data
	output stream_pkg::word_t o_data
);
	import stream_pkg::*;
	import fifo_pkg::*;

	// Word storage
	word_t             mem [0:(1<<LGFLEN)-1];
	// Single shared address
	logic [LGFLEN-1:0] addr;

	////////////////////////////////////////////////////////////
	// Address mux
	////////////////////////////////////////////////////////////

	// Read address only when the port is reading
	assign addr = (i_op == MEM_READ) ? i_rd_addr : i_wr_addr;

	////////////////////////////////////////////////////////////
	// Port
	////////////////////////////////////////////////////////////

	// o_data holds its value until the next read
	always_ff @(posedge i_clk) begin
		case (i_op)
			MEM_WRITE: begin
				mem[addr] <= i_data;
			end
			MEM_READ: begin
				o_data <= mem[addr];
			end
			default: begin
			end
		endcase
	end

endmodule

// File: sfifo/sfifo.sv
`timescale 1ns/1ns

module sfifo #(
	parameter int LGFLEN = 3
) (
	input  logic                   i_clk,
	input  logic                   i_rst,
	// Write side
	input  fifo_pkg::fifo_wr_t     i_wr,
	// Read side
	input  logic                   i_rd,
	output stream_pkg::word_t      o_data,
	// Status and level
	output fifo_pkg::fifo_status_t o_status,
	output logic [LGFLEN:0]        o_fill
);
	import fifo_pkg::*;

	// Pointers carry one extra bit to tell full from empty
	logic [LGFLEN:0] wr_ptr;
	logic [LGFLEN:0] rd_ptr;
	logic            full;
	logic            empty;
	// Effective write and read this cycle
	logic            w_wr;
	logic            w_rd;
	mem_op_t         mem_op;

	////////////////////////////////////////////////////////////
	// Accept logic
	////////////////////////////////////////////////////////////

	// A read takes the port, so a write in the same cycle is refused
	assign w_wr = i_wr.wr && !full && !i_rd;
	assign w_rd = i_rd && !empty;

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			wr_ptr <= '0;
		end else if (w_wr) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			rd_ptr <= '0;
		end else if (w_rd) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Level and flags
	////////////////////////////////////////////////////////////

	assign o_fill = wr_ptr - rd_ptr;
	assign full   = (o_fill == {1'b1, {LGFLEN{1'b0}}});
	assign empty  = (o_fill == '0);

	assign o_status.full  = full;
	assign o_status.empty = empty;
	// Not ready whenever the drain reads
	assign o_status.ready = !i_rd;

	////////////////////////////////////////////////////////////
	// RAM port
	////////////////////////////////////////////////////////////

	// Read wins the single port
	always_comb begin
		if (w_rd) begin
			mem_op = MEM_READ;
		end else if (w_wr) begin
			mem_op = MEM_WRITE;
		end else begin
			mem_op = MEM_IDLE;
		end
	end

	sfifo_mem #(
		.LGFLEN (LGFLEN)
	) u_mem (
		.i_clk     (i_clk),
		.i_op      (mem_op),
		.i_wr_addr (wr_ptr[LGFLEN-1:0]),
		.i_rd_addr (rd_ptr[LGFLEN-1:0]),
		.i_data    (i_wr.data),
		.o_data    (o_data)
	);

endmodule

// File: hw/byte_packer.sv
`timescale 1ns/1ns

module byte_packer (
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_in_valid,
	input  stream_pkg::byte_t      i_in_byte,
	input  fifo_pkg::fifo_status_t i_status,
	output fifo_pkg::fifo_wr_t     o_wr,
	output logic [15:0]            o_drop_count
);
	import stream_pkg::*;

	// Byte lane of the next incoming byte
	logic [1:0]  lane;
	// Bytes 0..2 of the word under assembly
	logic [23:0] asm_bytes;
	// Completed word waiting for the FIFO
	logic        pend_valid;
	word_t       pend_word;
	// Fourth byte of a word arrives this cycle
	logic        word_done;
	// Pending word meets a free port but a full FIFO
	logic        drop;

	assign word_done = i_in_valid && (lane == 2'd3);
	assign drop      = pend_valid && i_status.ready && i_status.full;

	////////////////////////////////////////////////////////////
	// Byte assembly
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			lane <= 2'd0;
		end else if (i_in_valid) begin
			lane <= lane + 2'd1;
		end
	end

	// Lanes 0..2 are held here, lane 3 goes straight to the pending word
	always_ff @(posedge i_clk) begin
		if (i_in_valid && (lane != 2'd3)) begin
			asm_bytes[lane*8 +: 8] <= i_in_byte;
		end
	end

	////////////////////////////////////////////////////////////
	// Pending word and write strobe
	////////////////////////////////////////////////////////////

	// Stays pending while the port is busy, clears on accept or drop
	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			pend_valid   <= 1'b0;
			o_drop_count <= 16'd0;
		end else begin
			pend_valid <= word_done || (pend_valid && !i_status.ready);
			if (drop) begin
				o_drop_count <= o_drop_count + 16'd1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (word_done) begin
			pend_word <= {i_in_byte, asm_bytes};
		end
	end

	// Strobe comes straight from the pending register
	assign o_wr.wr   = pend_valid;
	assign o_wr.data = pend_word;

endmodule

// File: hw/word_drain.sv
`timescale 1ns/1ns

module word_drain (
	input  logic                   i_clk,
	input  logic                   i_rst,
	// FIFO side
	input  fifo_pkg::fifo_status_t i_status,
	input  stream_pkg::word_t      i_data,
	output logic                   o_rd,
	// Output stream
	input  logic                   i_hold,
	output logic                   o_out_valid,
	output stream_pkg::byte_t      o_out_byte
);
	import stream_pkg::*;

	drain_state_t state;
	drain_state_t state_next;
	// Index of the byte on the output
	logic [1:0]   lane;
	// Captured word, shifted right one byte per output
	word_t        shift_word;
	// Last byte of the word leaves this cycle
	logic         last_byte;

	////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////

	// One-cycle read from idle, never under hold
	assign o_rd        = (state == DR_IDLE) && !i_status.empty && !i_hold;
	assign o_out_valid = (state == DR_SEND) && !i_hold;
	// Lowest byte is always the next in order
	assign o_out_byte  = shift_word[7:0];
	assign last_byte   = o_out_valid && (lane == 2'd3);

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			DR_IDLE: begin
				if (o_rd) begin
					state_next = DR_FETCH;
				end
			end
			// RAM data is valid during this cycle
			DR_FETCH: begin
				state_next = DR_SEND;
			end
			DR_SEND: begin
				if (last_byte) begin
					state_next = DR_IDLE;
				end
			end
			default: begin
				state_next = DR_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state <= DR_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Lane restarts on every capture
	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			lane <= 2'd0;
		end else if (state == DR_FETCH) begin
			lane <= 2'd0;
		end else if (o_out_valid) begin
			lane <= lane + 2'd1;
		end
	end

	////////////////////////////////////////////////////////////
	// Word capture and shift
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (state == DR_FETCH) begin
			shift_word <= i_data;
		end else if (o_out_valid) begin
			shift_word <= shift_word >> 8;
		end
	end

endmodule

// File: hw/byte_buffer_top.sv
`timescale 1ns/1ns

module byte_buffer_top #(
	parameter int LGFLEN = 3
) (
	input  logic                   i_clk,
	input  logic                   i_rst,
	// Byte input
	input  logic                   i_in_valid,
	input  stream_pkg::byte_t      i_in_byte,
	// Output pause level
	input  logic                   i_hold,
	// Byte output
	output logic                   o_out_valid,
	output stream_pkg::byte_t      o_out_byte,
	// Observation
	output logic [LGFLEN:0]        o_fill,
	output fifo_pkg::fifo_status_t o_status,
	output logic [15:0]            o_drop_count
);
	import stream_pkg::*;
	import fifo_pkg::*;

	// Packer to FIFO
	fifo_wr_t     wr_req;
	// FIFO to packer and drain
	fifo_status_t status;
	word_t        rd_data;
	// Drain to FIFO
	logic         rd;

	assign o_status = status;

	////////////////////////////////////////////////////////////
	// Blocks
	////////////////////////////////////////////////////////////

	byte_packer u_packer (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_in_valid   (i_in_valid),
		.i_in_byte    (i_in_byte),
		.i_status     (status),
		.o_wr         (wr_req),
		.o_drop_count (o_drop_count)
	);

	// Depth is 2**LGFLEN words
	sfifo #(
		.LGFLEN (LGFLEN)
	) u_fifo (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_wr     (wr_req),
		.i_rd     (rd),
		.o_data   (rd_data),
		.o_status (status),
		.o_fill   (o_fill)
	);

	word_drain u_drain (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_status    (status),
		.i_data      (rd_data),
		.o_rd        (rd),
		.i_hold      (i_hold),
		.o_out_valid (o_out_valid),
		.o_out_byte  (o_out_byte)
	);

endmodule

// File: verif/byte_buffer_props.sv
`timescale 1ns/1ns

module byte_buffer_props #(
	parameter int LGFLEN = 3
) (
	input logic                   i_clk,
	input logic                   i_rst,
	// Read strobe from the drain
	input logic                   i_rd,
	input fifo_pkg::fifo_status_t i_status,
	input logic [LGFLEN:0]        i_fill,
	// Internal write pointer of the controller
	input logic [LGFLEN:0]        i_wr_ptr
);

	localparam logic [LGFLEN:0] DEPTH = 1 << LGFLEN;

	////////////////////////////////////////////////////////////
	// FIFO controller rules
	////////////////////////////////////////////////////////////

	// Flags never both set
	a_flags_exclusive: assert property (@(posedge i_clk) disable iff (i_rst)
		!(i_status.full && i_status.empty))
		else $error("full and empty are high together");

	// Level bounded by the depth
	a_fill_bound: assert property (@(posedge i_clk) disable iff (i_rst)
		i_fill <= DEPTH)
		else $error("fill exceeds the FIFO depth");

	// Read owns the port
	a_ready_low: assert property (@(posedge i_clk) disable iff (i_rst)
		i_rd |-> !i_status.ready)
		else $error("ready is high during a read cycle");

	// No write slips in next to a read
	a_wr_ptr_hold: assert property (@(posedge i_clk) disable iff (i_rst)
		i_rd |=> (i_wr_ptr == $past(i_wr_ptr)))
		else $error("write pointer moved in a read cycle");

endmodule

bind sfifo byte_buffer_props #(
	.LGFLEN (LGFLEN)
) u_props (
	.i_clk    (i_clk),
	.i_rst    (i_rst),
	.i_rd     (i_rd),
	.i_status (o_status),
	.i_fill   (o_fill),
	.i_wr_ptr (wr_ptr)
);

// File: verif/byte_buffer_tb.sv
`timescale 1ns/1ns

module byte_buffer_tb;
	import stream_pkg::*;
	import fifo_pkg::*;

	localparam int LGFLEN   = 3;
	localparam int DEPTH    = 1 << LGFLEN;
	localparam int NUM_ROWS = 5;

	// One stimulus row: byte count, idle cycles between strobes, hold length
	typedef struct packed {
		logic [15:0] n_bytes;
		logic [7:0]  gap;
		logic [7:0]  hold_len;
	} row_t;

	////////////////////////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////////////////////////

	// Byte counts stay whole words since there is no partial flush
	// Rows without hold stay short enough that the FIFO never fills
	// Rows without hold run into each other, the drain is not waited for
	row_t rows [NUM_ROWS] = '{
		'{16'd32, 8'd2, 8'd0},
		// Back to back, the drain falls behind
		'{16'd48, 8'd0, 8'd0},
		// Words land while the drain still reads, busy retries
		'{16'd16, 8'd1, 8'd0},
		// Ten words under hold, two dropped
		'{16'd40, 8'd0, 8'd10},
		// Twelve words under hold, four dropped
		'{16'd48, 8'd0, 8'd6}
	};

	logic              i_clk;
	logic              i_rst;
	logic              i_in_valid;
	byte_t             i_in_byte;
	logic              i_hold;
	logic              o_out_valid;
	byte_t             o_out_byte;
	logic [LGFLEN:0]   o_fill;
	fifo_status_t      o_status;
	logic [15:0]       o_drop_count;

	// Scoreboard of bytes still expected on the output
	byte_t       exp_q [$];
	// Words accepted minus words popped
	int          mirror;
	logic [15:0] exp_drops;
	logic [15:0] exp_total;
	logic [15:0] out_count;
	logic [31:0] rng;
	int          value_errors;
	int          other_errors;
	int          cycles;
	int          limit;

	byte_buffer_top #(
		.LGFLEN (LGFLEN)
	) dut (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_in_valid   (i_in_valid),
		.i_in_byte    (i_in_byte),
		.i_hold       (i_hold),
		.o_out_valid  (o_out_valid),
		.o_out_byte   (o_out_byte),
		.o_fill       (o_fill),
		.o_status     (o_status),
		.o_drop_count (o_drop_count)
	);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// 32-bit xorshift step
	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic fifo_status_t make_status(input logic full, input logic empty,
		input logic ready);
		fifo_status_t s;
		s.full  = full;
		s.empty = empty;
		s.ready = ready;
		return s;
	endfunction

	// Budget grows with the bytes and holds of every row
	function automatic int timeout_limit();
		int sum;
		sum = 200;
		for (int r = 0; r < NUM_ROWS; r++) begin
			sum = sum + 20 * int'(rows[r].n_bytes) + int'(rows[r].hold_len);
		end
		return sum;
	endfunction

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("error: %s got 0x%02h expected 0x%02h", name, got, exp);
		end
	endtask

	task automatic check_status(input string name, input fifo_status_t got,
		input fifo_status_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("error: %s got 0x%1h expected 0x%1h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("error: %s got 0x%04h expected 0x%04h", name, got, exp);
		end
	endtask

	// Called 1 ns after a rising edge, returns at the same phase
	task automatic drive_byte(input byte_t b, input int gap);
		i_in_valid = 1'b1;
		i_in_byte  = b;
		@(posedge i_clk);
		#1;
		i_in_valid = 1'b0;
		repeat (gap) begin
			@(posedge i_clk);
			#1;
		end
	endtask

	// All expected bytes out, FIFO empty again
	task automatic wait_drained();
		while (exp_q.size() != 0) begin
			@(posedge i_clk);
		end
		// Room for any stray byte to show up
		repeat (12) @(posedge i_clk);
		#1;
		check_count("o_fill", 16'(o_fill), 16'd0);
		check_status("o_status", o_status, make_status(1'b0, 1'b1, 1'b1));
		check_count("o_drop_count", o_drop_count, exp_drops);
	endtask

	task automatic run_row(input row_t row);
		int    n_words;
		byte_t b;
		n_words = int'(row.n_bytes) / 4;
		if (row.hold_len != 0) begin
			i_hold = 1'b1;
		end
		for (int w = 0; w < n_words; w++) begin
			for (int k = 0; k < 4; k++) begin
				rng = next_random(rng);
				b   = rng[7:0];
				exp_q.push_back(b);
				drive_byte(b, int'(row.gap));
			end
			// Nothing pops under hold, so a ninth word meets a full FIFO
			if (row.hold_len != 0 && mirror >= DEPTH) begin
				repeat (4) void'(exp_q.pop_back());
				exp_drops++;
			end else begin
				mirror++;
				exp_total = exp_total + 16'd4;
			end
		end
		if (row.hold_len != 0) begin
			repeat (row.hold_len) @(posedge i_clk);
			#1;
			check_count("o_fill", 16'(o_fill), 16'(mirror));
			check_status("o_status", o_status,
				make_status(mirror == DEPTH, mirror == 0, 1'b1));
			check_count("o_drop_count", o_drop_count, exp_drops);
			i_hold = 1'b0;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Output monitor
	////////////////////////////////////////////////////////////

	// Sampled mid-cycle where the output is settled
	always @(negedge i_clk) begin
		if (!i_rst && o_out_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				other_errors++;
				$display("output byte 0x%02h appeared with no byte left to expect",
					o_out_byte);
			end else begin
				check_byte("o_out_byte", o_out_byte, exp_q.pop_front());
			end
			out_count = out_count + 16'd1;
			// Last byte of a word closes its pop
			if (out_count[1:0] == 2'd0) begin
				mirror--;
			end
		end
	end

	// Run limit
	always @(posedge i_clk) begin
		cycles++;
		if (cycles >= limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		i_rst        = 1'b1;
		i_in_valid   = 1'b0;
		i_in_byte    = 8'h00;
		i_hold       = 1'b0;
		mirror       = 0;
		exp_drops    = 16'd0;
		exp_total    = 16'd0;
		out_count    = 16'd0;
		rng          = 32'd68;
		value_errors = 0;
		other_errors = 0;
		cycles       = 0;
		limit        = timeout_limit();

		repeat (5) @(posedge i_clk);
		#1;
		i_rst = 1'b0;

		// State right after reset
		check_count("o_out_valid", 16'(o_out_valid), 16'd0);
		check_count("o_fill", 16'(o_fill), 16'd0);
		check_status("o_status", o_status, make_status(1'b0, 1'b1, 1'b1));
		check_count("o_drop_count", o_drop_count, 16'd0);

		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(rows[r]);
			// Hold rows start and end with an empty FIFO and an idle drain
			if (r == NUM_ROWS - 1 || rows[r].hold_len != 0 ||
				rows[r + 1].hold_len != 0) begin
				wait_drained();
			end
		end

		check_count("output byte count", out_count, exp_total);

		$display("summary: %0d value errors, %0d other errors, %0d bytes out, %0d drops",
			value_errors, other_errors, out_count, exp_drops);
		if (value_errors == 0 && other_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: list.f
common/stream_pkg.sv
common/fifo_pkg.sv
sfifo/sfifo_mem.sv
sfifo/sfifo.sv
hw/byte_packer.sv
hw/word_drain.sv
hw/byte_buffer_top.sv
verif/byte_buffer_props.sv
verif/byte_buffer_tb.sv
